/* design/gpio_map_pkg.sv */
package gpio_map_pkg;

	// Number of GPIO pins seen by the register block
	localparam int N_GPIOS = 8;

	// Status LED, driven from the OUT and OE registers
	localparam int PIN_LED = 0;

	// Button inputs, one pin each
	localparam int PIN_DPAD_U = 1;
	localparam int PIN_DPAD_D = 2;
	localparam int PIN_DPAD_L = 3;
	localparam int PIN_DPAD_R = 4;
	localparam int PIN_BTN_A  = 5;

	// Spare outputs, also mirrored on the LEDs
	localparam int PIN_AUX0 = 6;
	localparam int PIN_AUX1 = 7;

	// Buttons are numbered dpad_u .. btn_a from bit 0 upwards
	localparam int N_BUTTONS = 5;

endpackage

/* design/io_bus_pkg.sv */
package io_bus_pkg;

	// Register word address width
	localparam int W_ADDR = 4;

	// Register select, decoded from the bus address
	typedef enum logic [W_ADDR-1:0] {
		REG_OUT  = 4'd0,
		REG_OE   = 4'd1,
		REG_IN   = 4'd2,
		REG_RISE = 4'd3
	} reg_sel_e;

	// Reset generator FSM
	typedef enum logic [1:0] {
		RST_HOLD,
		RST_COUNT,
		RST_DONE
	} rst_state_e;

endpackage

/* design/io_bus_if.sv */
interface io_bus_if;

	import io_bus_pkg::*;
	import gpio_map_pkg::*;

	// Single-cycle strobe bus, no back-pressure
	logic [W_ADDR-1:0]  addr;
	logic [N_GPIOS-1:0] wdata;
	logic               write;
	logic               read;

	// Held from the cycle after a read until the next read
	logic [N_GPIOS-1:0] rdata;

	modport master (
		output addr,
		output wdata,
		output write,
		output read,
		input  rdata
	);

	modport slave (
		input  addr,
		input  wdata,
		input  write,
		input  read,
		output rdata
	);

endinterface

/* design/fpga_reset.sv */
module fpga_reset #(
	parameter int COUNT = 200
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic pll_locked,
	output logic rst_sys
);

	import io_bus_pkg::*;

	localparam int W_CNT = $clog2(COUNT + 1);

	logic             lock_meta;
	logic             lock_sync;
	logic             hold;
	logic [W_CNT-1:0] count;
	rst_state_e       state;
	rst_state_e       state_next;

	// Lock comes from the PLL, which is not related to clk_sys timing
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lock_meta <= 1'b0;
			lock_sync <= 1'b0;
		end else begin
			lock_meta <= pll_locked;
			lock_sync <= lock_meta;
		end
	end

	assign hold = reset || !lock_sync;

	always_comb begin
		state_next = state;
		case (state)
			RST_HOLD: begin
				if (!hold)
					state_next = RST_COUNT;
			end
			RST_COUNT: begin
				if (hold)
					state_next = RST_HOLD;
				else if (count == W_CNT'(COUNT - 1))
					state_next = RST_DONE;
			end
			RST_DONE: begin
				// Losing lock puts the system back into reset
				if (hold)
					state_next = RST_HOLD;
			end
			default: state_next = RST_HOLD;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= RST_HOLD;
			count   <= '0;
			rst_sys <= 1'b1;
		end else begin
			state   <= state_next;
			rst_sys <= state_next != RST_DONE;
			if (state == RST_COUNT)
				count <= count + 1'b1;
			else
				count <= '0;
		end
	end

endmodule

/* design/pad_debounce.sv */
module pad_debounce #(
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic                                clk_sys,
	input  logic                                rst_sys,
	input  logic [gpio_map_pkg::N_BUTTONS-1:0] pad_n,
	output logic [gpio_map_pkg::N_BUTTONS-1:0] pressed
);

	import gpio_map_pkg::*;

	localparam int W_CNT = $clog2(DEBOUNCE_CYCLES + 1);

	logic [N_BUTTONS-1:0] level_meta;
	logic [N_BUTTONS-1:0] level_sync;
	logic [W_CNT-1:0]     stable_cnt [N_BUTTONS];

	// Pads are active low, so invert before the synchronizer
	always_ff @(posedge clk_sys) begin
		if (rst_sys) begin
			level_meta <= '0;
			level_sync <= '0;
		end else begin
			level_meta <= ~pad_n;
			level_sync <= level_meta;
		end
	end

	// Each button counts consecutive samples that disagree with the
	// accepted level, and any agreeing sample restarts the count
	always_ff @(posedge clk_sys) begin
		if (rst_sys) begin
			pressed <= '0;
			for (int i = 0; i < N_BUTTONS; i++)
				stable_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < N_BUTTONS; i++) begin
				if (level_sync[i] == pressed[i]) begin
					stable_cnt[i] <= '0;
				end else if (stable_cnt[i] == W_CNT'(DEBOUNCE_CYCLES - 1)) begin
					// Enough stable samples, take the new level
					pressed[i]    <= level_sync[i];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

/* design/gpio_regs.sv */
module gpio_regs (
	input  logic                                clk_sys,
	input  logic                                rst_sys,
	io_bus_if.slave                             bus,
	input  logic [gpio_map_pkg::N_BUTTONS-1:0] pressed,
	output logic [gpio_map_pkg::N_GPIOS-1:0]   pad_out,
	output logic [gpio_map_pkg::N_GPIOS-1:0]   pad_oe
);

	import gpio_map_pkg::*;
	import io_bus_pkg::*;

	// Only pins with a button behind them have a rise bit
	localparam logic [N_GPIOS-1:0] BTN_MASK = N_GPIOS'(
		(1 << PIN_DPAD_U) |
		(1 << PIN_DPAD_D) |
		(1 << PIN_DPAD_L) |
		(1 << PIN_DPAD_R) |
		(1 << PIN_BTN_A)
	);

	reg_sel_e           sel;
	logic               wr_out;
	logic               wr_oe;
	logic               wr_rise;
	logic [N_GPIOS-1:0] in_val;
	logic [N_GPIOS-1:0] in_prev;
	logic [N_GPIOS-1:0] rise;
	logic [N_GPIOS-1:0] rise_set;
	logic [N_GPIOS-1:0] rise_clr;
	logic [N_GPIOS-1:0] rd_mux;

	assign sel = reg_sel_e'(bus.addr);

	assign wr_out  = bus.write && sel == REG_OUT;
	assign wr_oe   = bus.write && sel == REG_OE;
	assign wr_rise = bus.write && sel == REG_RISE;

	// IN register follows the board pin map
	always_comb begin
		in_val             = '0;
		in_val[PIN_DPAD_U] = pressed[0];
		in_val[PIN_DPAD_D] = pressed[1];
		in_val[PIN_DPAD_L] = pressed[2];
		in_val[PIN_DPAD_R] = pressed[3];
		in_val[PIN_BTN_A]  = pressed[4];
	end

	assign rise_set = in_val & ~in_prev;
	// Write 1 to clear
	assign rise_clr = wr_rise ? (bus.wdata & BTN_MASK) : '0;

	always_comb begin
		case (sel)
			REG_OUT:  rd_mux = pad_out;
			REG_OE:   rd_mux = pad_oe;
			REG_IN:   rd_mux = in_val;
			REG_RISE: rd_mux = rise;
			default:  rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (rst_sys) begin
			pad_out   <= '0;
			pad_oe    <= '0;
			in_prev   <= '0;
			rise      <= '0;
			bus.rdata <= '0;
		end else begin
			if (wr_out)
				pad_out <= bus.wdata;
			if (wr_oe)
				pad_oe <= bus.wdata;
			in_prev <= in_val;
			// A new edge beats a simultaneous clear
			rise <= (rise & ~rise_clr) | rise_set;
			if (bus.read)
				bus.rdata <= rd_mux;
		end
	end

endmodule

/* design/riscboy_io_top.sv */
module riscboy_io_top #(
	parameter int RESET_COUNT     = 200,
	parameter int DEBOUNCE_CYCLES = 8
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              pll_locked,

	input  logic                              dpad_u,
	input  logic                              dpad_d,
	input  logic                              dpad_l,
	input  logic                              dpad_r,
	input  logic                              btn_a,

	input  logic [io_bus_pkg::W_ADDR-1:0]    bus_addr,
	input  logic [gpio_map_pkg::N_GPIOS-1:0] bus_wdata,
	input  logic                              bus_write,
	input  logic                              bus_read,
	output logic [gpio_map_pkg::N_GPIOS-1:0] bus_rdata,

	output logic [gpio_map_pkg::N_GPIOS-1:0] gpio_out,
	output logic [gpio_map_pkg::N_GPIOS-1:0] gpio_oe,
	output logic [7:0]                        led
);

	import gpio_map_pkg::*;

	logic                 rst_sys;
	logic [N_BUTTONS-1:0] pad_n;
	logic [N_BUTTONS-1:0] pressed;

	io_bus_if bus ();

	// Top ports act as the bus master
	assign bus.addr  = bus_addr;
	assign bus.wdata = bus_wdata;
	assign bus.write = bus_write;
	assign bus.read  = bus_read;
	assign bus_rdata = bus.rdata;

	// Button order matches the pin map, dpad_u in bit 0
	assign pad_n = {btn_a, dpad_r, dpad_l, dpad_d, dpad_u};

	fpga_reset #(
		.COUNT (RESET_COUNT)
	) rstgen (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pll_locked (pll_locked),
		.rst_sys    (rst_sys)
	);

	pad_debounce #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) buttons (
		.clk_sys (clk_sys),
		.rst_sys (rst_sys),
		.pad_n   (pad_n),
		.pressed (pressed)
	);

	gpio_regs gpio (
		.clk_sys (clk_sys),
		.rst_sys (rst_sys),
		.bus     (bus.slave),
		.pressed (pressed),
		.pad_out (gpio_out),
		.pad_oe  (gpio_oe)
	);

	// Output pins light only when enabled, buttons show their debounced state
	always_comb begin
		led             = '0;
		led[PIN_LED]    = gpio_out[PIN_LED] && gpio_oe[PIN_LED];
		led[PIN_DPAD_U] = pressed[0];
		led[PIN_DPAD_D] = pressed[1];
		led[PIN_DPAD_L] = pressed[2];
		led[PIN_DPAD_R] = pressed[3];
		led[PIN_BTN_A]  = pressed[4];
		led[PIN_AUX0]   = gpio_out[PIN_AUX0] && gpio_oe[PIN_AUX0];
		led[PIN_AUX1]   = gpio_out[PIN_AUX1] && gpio_oe[PIN_AUX1];
	end

endmodule

/* tb/riscboy_io_assertions.sv */
module riscboy_io_assertions #(
	parameter int RESET_COUNT = 200
) (
	input logic                              clk_sys,
	input logic                              reset,
	input logic [io_bus_pkg::W_ADDR-1:0]    bus_addr,
	input logic [gpio_map_pkg::N_GPIOS-1:0] bus_wdata,
	input logic                              bus_write,
	input logic                              bus_read,
	input logic [gpio_map_pkg::N_GPIOS-1:0] bus_rdata,
	input logic [gpio_map_pkg::N_GPIOS-1:0] gpio_out,
	input logic [gpio_map_pkg::N_GPIOS-1:0] gpio_oe,
	input logic [7:0]                        led
);

	import gpio_map_pkg::*;
	import io_bus_pkg::*;

	// Writes land only once the reset generator has let go
	localparam int SETTLE = RESET_COUNT + 4;

	// Reset cycles seen so far, saturating at 3
	logic [1:0]         rst_age = '0;
	logic [15:0]        run_cyc = '0;
	logic               settled;
	logic [N_GPIOS-1:0] sh_out = '0;
	logic [N_GPIOS-1:0] sh_oe = '0;
	int                 fail_count = 0;

	assign settled = run_cyc >= 16'(SETTLE);

	always @(posedge clk_sys) begin
		if (reset) begin
			run_cyc <= '0;
			sh_out  <= '0;
			sh_oe   <= '0;
			if (rst_age != 2'd3)
				rst_age <= rst_age + 1'b1;
		end else begin
			if (run_cyc != '1)
				run_cyc <= run_cyc + 1'b1;
			if (settled && bus_write && bus_addr == REG_OUT)
				sh_out <= bus_wdata;
			if (settled && bus_write && bus_addr == REG_OE)
				sh_oe <= bus_wdata;
		end
	end

	a_zero_in_reset: assert property (@(posedge clk_sys)
		rst_age == 2'd3 && (reset || $past(reset)) |->
			gpio_oe == '0 && gpio_out == '0 && led == '0 && bus_rdata == '0)
	else begin
		$error("outputs not zero during reset or on the cycle after it");
		fail_count = fail_count + 1;
	end

	// Still inside the settle count, so bus writes must not reach OE
	a_oe_held: assert property (@(posedge clk_sys)
		rst_age == 2'd3 && !reset && run_cyc <= 16'(RESET_COUNT) |-> gpio_oe == '0)
	else begin
		$error("gpio_oe changed while the system was still in reset");
		fail_count = fail_count + 1;
	end

	a_pins_follow_writes: assert property (@(posedge clk_sys)
		settled |-> gpio_out == sh_out && gpio_oe == sh_oe)
	else begin
		$error("gpio_out or gpio_oe differs from the last write");
		fail_count = fail_count + 1;
	end

	a_led_map: assert property (@(posedge clk_sys)
		rst_age == 2'd3 |->
			led[PIN_LED] == (gpio_out[PIN_LED] && gpio_oe[PIN_LED]) &&
			led[PIN_AUX0] == (gpio_out[PIN_AUX0] && gpio_oe[PIN_AUX0]) &&
			led[PIN_AUX1] == (gpio_out[PIN_AUX1] && gpio_oe[PIN_AUX1]))
	else begin
		$error("led output pins do not match out and oe");
		fail_count = fail_count + 1;
	end

	a_read_out: assert property (@(posedge clk_sys)
		settled && bus_read && bus_addr == REG_OUT |=> bus_rdata == $past(sh_out))
	else begin
		$error("read of OUT returned the wrong value");
		fail_count = fail_count + 1;
	end

	a_read_oe: assert property (@(posedge clk_sys)
		settled && bus_read && bus_addr == REG_OE |=> bus_rdata == $past(sh_oe))
	else begin
		$error("read of OE returned the wrong value");
		fail_count = fail_count + 1;
	end

	a_read_unmapped: assert property (@(posedge clk_sys)
		settled && bus_read && bus_addr > REG_RISE |=> bus_rdata == '0)
	else begin
		$error("read of an unmapped address returned nonzero data");
		fail_count = fail_count + 1;
	end

	a_rdata_hold: assert property (@(posedge clk_sys)
		settled && !bus_read |=> $stable(bus_rdata))
	else begin
		$error("bus_rdata changed without a read");
		fail_count = fail_count + 1;
	end

endmodule

bind riscboy_io_top riscboy_io_assertions #(
	.RESET_COUNT (RESET_COUNT)
) chk (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.bus_addr  (bus_addr),
	.bus_wdata (bus_wdata),
	.bus_write (bus_write),
	.bus_read  (bus_read),
	.bus_rdata (bus_rdata),
	.gpio_out  (gpio_out),
	.gpio_oe   (gpio_oe),
	.led       (led)
);

/* tb/tb_riscboy_io.sv */
module tb_riscboy_io;

	import gpio_map_pkg::*;
	import io_bus_pkg::*;

	localparam int RESET_COUNT     = 20;
	localparam int DEBOUNCE_CYCLES = 4;
	localparam int MAX_CYCLES      = 5000;

	// Button number to GPIO pin, dpad_u first
	localparam int BTN_PIN [N_BUTTONS] = '{
		PIN_DPAD_U, PIN_DPAD_D, PIN_DPAD_L, PIN_DPAD_R, PIN_BTN_A
	};

	logic                 clk_sys;
	logic                 reset;
	logic                 pll_locked;
	logic [N_BUTTONS-1:0] pad_n;
	logic [W_ADDR-1:0]    bus_addr;
	logic [N_GPIOS-1:0]   bus_wdata;
	logic                 bus_write;
	logic                 bus_read;
	logic [N_GPIOS-1:0]   bus_rdata;
	logic [N_GPIOS-1:0]   gpio_out;
	logic [N_GPIOS-1:0]   gpio_oe;
	logic [7:0]           led;

	// Scoreboard of the register contents
	logic [N_GPIOS-1:0] exp_out;
	logic [N_GPIOS-1:0] exp_oe;
	logic [N_GPIOS-1:0] exp_rise;
	int                 seed;

	riscboy_io_top #(
		.RESET_COUNT     (RESET_COUNT),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) uut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pll_locked (pll_locked),
		.dpad_u     (pad_n[0]),
		.dpad_d     (pad_n[1]),
		.dpad_l     (pad_n[2]),
		.dpad_r     (pad_n[3]),
		.btn_a      (pad_n[4]),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.bus_write  (bus_write),
		.bus_read   (bus_read),
		.bus_rdata  (bus_rdata),
		.gpio_out   (gpio_out),
		.gpio_oe    (gpio_oe),
		.led        (led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [N_GPIOS-1:0] got,
			input logic [N_GPIOS-1:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error: %s expected 0x%h, got 0x%h", name, exp, got));
	endtask

	function automatic logic [N_GPIOS-1:0] pin_mask(input int btn);
		logic [N_GPIOS-1:0] m;
		m = '0;
		m[BTN_PIN[btn]] = 1'b1;
		return m;
	endfunction

	task automatic bus_write_reg(input logic [W_ADDR-1:0] addr, input logic [N_GPIOS-1:0] data);
		@(posedge clk_sys);
		bus_addr  <= addr;
		bus_wdata <= data;
		bus_write <= 1'b1;
		@(posedge clk_sys);
		bus_write <= 1'b0;
	endtask

	// Read data is sampled one edge after the capture edge
	task automatic bus_read_reg(input logic [W_ADDR-1:0] addr, output logic [N_GPIOS-1:0] data);
		@(posedge clk_sys);
		bus_addr <= addr;
		bus_read <= 1'b1;
		@(posedge clk_sys);
		bus_read <= 1'b0;
		@(posedge clk_sys);
		data = bus_rdata;
	endtask

	task automatic expect_read(input logic [W_ADDR-1:0] addr, input logic [N_GPIOS-1:0] exp);
		logic [N_GPIOS-1:0] got;
		bus_read_reg(addr, got);
		check_value($sformatf("bus_rdata at addr 0x%h", addr), got, exp);
	endtask

	task automatic write_and_check(input logic [W_ADDR-1:0] addr, input logic [N_GPIOS-1:0] data);
		bus_write_reg(addr, data);
		case (addr)
			REG_OUT:  exp_out = data;
			REG_OE:   exp_oe = data;
			REG_RISE: exp_rise = exp_rise & ~data;
			default:  ;
		endcase
		@(posedge clk_sys);
		check_value("gpio_out", gpio_out, exp_out);
		check_value("gpio_oe", gpio_oe, exp_oe);
	endtask

	task automatic wait_led(input int pin, input logic level);
		int n;
		n = 0;
		while (led[pin] !== level) begin
			if (n == DEBOUNCE_CYCLES + 4)
				report_failure($sformatf("led[%0d] did not reach %0b in time", pin, level));
			@(posedge clk_sys);
			n++;
		end
	endtask

	task automatic press_button(input int btn);
		@(posedge clk_sys);
		pad_n[btn] <= 1'b0;
		wait_led(BTN_PIN[btn], 1'b1);
	endtask

	task automatic release_button(input int btn);
		@(posedge clk_sys);
		pad_n[btn] <= 1'b1;
		wait_led(BTN_PIN[btn], 1'b0);
	endtask

	always @(posedge clk_sys) begin
		if (uut.chk.fail_count != 0)
			report_failure("an assertion in the bound checker failed");
	end

	initial begin
		repeat (MAX_CYCLES) @(posedge clk_sys);
		report_failure("simulation ran past its cycle limit");
	end

	initial begin
		logic [N_GPIOS-1:0] data;
		logic [W_ADDR-1:0]  addr;
		int                 tries;
		seed       = 25383;
		reset      = 1'b1;
		pll_locked = 1'b0;
		pad_n      = '1;
		bus_addr   = '0;
		bus_wdata  = '0;
		bus_write  = 1'b0;
		bus_read   = 1'b0;
		exp_out    = '0;
		exp_oe     = '0;
		exp_rise   = '0;

		repeat (3) @(posedge clk_sys);
		pll_locked <= 1'b1;
		repeat (7) @(posedge clk_sys);
		reset <= 1'b0;

		// Early write lands inside the settle count
		bus_write_reg(REG_OE, 8'hff);
		@(posedge clk_sys);
		check_value("gpio_oe", gpio_oe, 8'h00);

		repeat (RESET_COUNT + 8) @(posedge clk_sys);
		tries = 0;
		data  = '0;
		while (data !== 8'h5a) begin
			if (tries == 8)
				report_failure("reset never released, OE readback did not match");
			bus_write_reg(REG_OE, 8'h5a);
			bus_read_reg(REG_OE, data);
			tries++;
		end
		exp_oe = 8'h5a;

		for (int i = 0; i < 16; i++) begin
			data = N_GPIOS'($random(seed));
			addr = ($random(seed) & 1) ? REG_OE : REG_OUT;
			write_and_check(addr, data);
			expect_read(addr, data);
		end

		// IN is read only and unmapped space reads as zero
		write_and_check(REG_IN, N_GPIOS'($random(seed)));
		for (int a = 4; a < 16; a++) begin
			write_and_check(W_ADDR'(a), N_GPIOS'($random(seed)));
			expect_read(W_ADDR'(a), 8'h00);
		end
		expect_read(REG_OUT, exp_out);
		expect_read(REG_OE, exp_oe);

		write_and_check(REG_OUT, 8'hc1);
		write_and_check(REG_OE, 8'h41);
		check_value("led", led & 8'hc1, exp_out & exp_oe & 8'hc1);

		expect_read(REG_IN, 8'h00);
		expect_read(REG_RISE, 8'h00);
		for (int b = 0; b < N_BUTTONS; b++) begin
			press_button(b);
			exp_rise = exp_rise | pin_mask(b);
			expect_read(REG_IN, pin_mask(b));
			expect_read(REG_RISE, exp_rise);
			release_button(b);
			expect_read(REG_IN, 8'h00);
			expect_read(REG_RISE, exp_rise);
		end

		write_and_check(REG_RISE, pin_mask(0) | pin_mask(2));
		expect_read(REG_RISE, exp_rise);
		write_and_check(REG_RISE, 8'hff);
		expect_read(REG_RISE, 8'h00);

		// Glitch shorter than the debounce window
		@(posedge clk_sys);
		pad_n[1] <= 1'b0;
		repeat (DEBOUNCE_CYCLES - 2) @(posedge clk_sys);
		pad_n[1] <= 1'b1;
		repeat (DEBOUNCE_CYCLES + 6) begin
			@(posedge clk_sys);
			check_value("led[5:1]", N_GPIOS'(led[5:1]), 8'h00);
		end
		expect_read(REG_RISE, 8'h00);

		repeat (4) @(posedge clk_sys);
		if (uut.chk.fail_count != 0) begin
			report_failure("an assertion in the bound checker failed");
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

/* riscboy_io.f */
design/gpio_map_pkg.sv
design/io_bus_pkg.sv
design/io_bus_if.sv
design/fpga_reset.sv
design/pad_debounce.sv
design/gpio_regs.sv
design/riscboy_io_top.sv
tb/riscboy_io_assertions.sv
tb/tb_riscboy_io.sv
